//--- hdl/rv_trap_pkg.sv
// Trap unit package with the shared widths, M-mode CSR addresses and fixed CSR values.
package rv_trap_pkg;

    // One CSR data word.
    typedef logic [31:0] xlen_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // Program counter, halfword aligned.
    typedef logic [31:1] pc_t;
    // Trap vector base, word aligned.
    typedef logic [31:2] tvec_t;
    // Interrupt or trap number.
    typedef logic [4:0]  cause_t;
    // External interrupt lines 16 to 31.
    typedef logic [31:16] irq_t;

    // Machine trap setup.
    parameter csr_addr_t CSR_MSTATUS    = 12'h300;
    parameter csr_addr_t CSR_MISA       = 12'h301;
    parameter csr_addr_t CSR_MEDELEG    = 12'h302;
    parameter csr_addr_t CSR_MIDELEG    = 12'h303;
    parameter csr_addr_t CSR_MIE        = 12'h304;
    parameter csr_addr_t CSR_MTVEC      = 12'h305;
    parameter csr_addr_t CSR_MSTATUSH   = 12'h310;
    // Machine trap handling.
    parameter csr_addr_t CSR_MSCRATCH   = 12'h340;
    parameter csr_addr_t CSR_MEPC       = 12'h341;
    parameter csr_addr_t CSR_MCAUSE     = 12'h342;
    parameter csr_addr_t CSR_MTVAL      = 12'h343;
    parameter csr_addr_t CSR_MIP        = 12'h344;
    // Machine information, all read-only.
    parameter csr_addr_t CSR_MVENDORID  = 12'hf11;
    parameter csr_addr_t CSR_MARCHID    = 12'hf12;
    parameter csr_addr_t CSR_MIMPID     = 12'hf13;
    parameter csr_addr_t CSR_MHARTID    = 12'hf14;
    parameter csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Field positions in mstatus and mcause.
    parameter int MSTATUS_MIE_BIT  = 3;
    parameter int MSTATUS_MPIE_BIT = 7;
    parameter int MCAUSE_INT_BIT   = 31;

    // MXL of 1 for 32 bits, with the I and M extension bits.
    parameter xlen_t MISA_VALUE = 32'h4000_1100;

    // First external interrupt number.
    parameter int IRQ_BASE = 16;

endpackage

//--- hdl/csr_file.sv
// M-mode CSR file with read and permission decode and the trap, MRET and write updates.
`timescale 1ns/10ps

module csr_file #(
    // Value returned by mhartid.
    parameter rv_trap_pkg::xlen_t hartid = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst,

    // CSR access port.
    input  rv_trap_pkg::csr_addr_t csr_addr,
    input  logic                   csr_we,
    input  rv_trap_pkg::xlen_t     csr_wdata,
    output rv_trap_pkg::xlen_t     csr_rdata,
    output logic                   csr_exists,
    output logic                   csr_rdonly,

    // Return strobe.
    input  logic                   mret,

    // Trap dispatch from the arbiter.
    input  logic                   take_irq,
    input  logic                   take_trap,
    input  rv_trap_pkg::cause_t    trap_cause,
    input  rv_trap_pkg::pc_t       trap_epc,
    input  rv_trap_pkg::irq_t      irq_pending,

    // State seen by the arbiter and the return path.
    output logic                   mstatus_mie,
    output rv_trap_pkg::xlen_t     mie,
    output rv_trap_pkg::tvec_t     mtvec,
    output rv_trap_pkg::pc_t       mepc
);

    // Previous interrupt enable, saved on trap entry.
    logic                mstatus_mpie;
    // Scratch word for the handler.
    rv_trap_pkg::xlen_t  mscratch;
    // Cause number and interrupt flag.
    rv_trap_pkg::cause_t mcause_no;
    logic                mcause_int;

    // Full 32-bit views of the packed registers.
    rv_trap_pkg::xlen_t  mstatus_word;
    rv_trap_pkg::xlen_t  mcause_word;
    rv_trap_pkg::xlen_t  mip_word;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[rv_trap_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_word[rv_trap_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;

        mcause_word = '0;
        mcause_word[rv_trap_pkg::MCAUSE_INT_BIT] = mcause_int;
        mcause_word[4:0] = mcause_no;

        // Only enabled lines show as pending.
        mip_word = '0;
        mip_word[31:rv_trap_pkg::IRQ_BASE] = irq_pending;
        mip_word = mip_word & mie;
    end

    // Read and permission decode.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            rv_trap_pkg::CSR_MSTATUS:  csr_rdata = mstatus_word;
            // Writable, but writes have no effect.
            rv_trap_pkg::CSR_MISA:     csr_rdata = rv_trap_pkg::MISA_VALUE;
            rv_trap_pkg::CSR_MIE:      csr_rdata = mie;
            rv_trap_pkg::CSR_MTVEC:    csr_rdata = {mtvec, 2'b00};
            rv_trap_pkg::CSR_MIP:      csr_rdata = mip_word;
            rv_trap_pkg::CSR_MSCRATCH: csr_rdata = mscratch;
            rv_trap_pkg::CSR_MEPC:     csr_rdata = {mepc, 1'b0};
            rv_trap_pkg::CSR_MCAUSE:   csr_rdata = mcause_word;
            // No delegation, no mtval, no high status half.
            rv_trap_pkg::CSR_MEDELEG,
            rv_trap_pkg::CSR_MIDELEG,
            rv_trap_pkg::CSR_MSTATUSH,
            rv_trap_pkg::CSR_MTVAL:    csr_rdata = '0;
            // ID registers read as zero.
            rv_trap_pkg::CSR_MVENDORID,
            rv_trap_pkg::CSR_MARCHID,
            rv_trap_pkg::CSR_MIMPID,
            rv_trap_pkg::CSR_MCONFIGPTR: csr_rdonly = 1'b1;
            rv_trap_pkg::CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            default: csr_exists = 1'b0;
        endcase
    end

    // Updates, highest priority first.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_no    <= '0;
            mcause_int   <= 1'b0;
        end else if (mret) begin
            // Return restores the saved enable.
            mstatus_mie <= mstatus_mpie;
        end else if (take_irq || take_trap) begin
            // Trap entry, interrupts off until return.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= trap_epc;
            mcause_int   <= take_irq;
            mcause_no    <= trap_cause;
        end else if (csr_we) begin
            case (csr_addr)
                rv_trap_pkg::CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[rv_trap_pkg::MSTATUS_MIE_BIT];
                    mstatus_mpie <= csr_wdata[rv_trap_pkg::MSTATUS_MPIE_BIT];
                end
                rv_trap_pkg::CSR_MIE:      mie <= csr_wdata;
                rv_trap_pkg::CSR_MTVEC:    mtvec <= csr_wdata[31:2];
                rv_trap_pkg::CSR_MSCRATCH: mscratch <= csr_wdata;
                rv_trap_pkg::CSR_MEPC:     mepc <= csr_wdata[31:1];
                rv_trap_pkg::CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[rv_trap_pkg::MCAUSE_INT_BIT];
                    mcause_no  <= csr_wdata[4:0];
                end
                // Other addresses hold constants.
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/trap_arbiter.sv
// Trap arbiter that latches interrupts, picks the lowest enabled one and dispatches traps.
`timescale 1ns/10ps

module trap_arbiter #(
    // Edges that mstatus.MIE must have been set for.
    parameter int mie_delay = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  rv_trap_pkg::irq_t   irq,

    // Retiring instruction.
    input  logic                retire_valid,
    input  logic                retire_trap,
    input  rv_trap_pkg::cause_t retire_cause,
    input  rv_trap_pkg::pc_t    retire_pc,

    // CSR state.
    input  logic                mstatus_mie,
    input  rv_trap_pkg::xlen_t  mie,
    input  rv_trap_pkg::tvec_t  mtvec,

    // Dispatch.
    output rv_trap_pkg::irq_t   irq_pending,
    output logic                take_irq,
    output logic                take_trap,
    output rv_trap_pkg::cause_t trap_cause,
    output rv_trap_pkg::pc_t    trap_epc,
    output logic                exception,
    output rv_trap_pkg::tvec_t  tvec
);

    // Enable history, newest sample in bit 0.
    logic [mie_delay-1:0] mie_hist;
    logic [mie_delay:0]   mie_hist_next;
    // Pending and enabled lines.
    rv_trap_pkg::irq_t    irq_masked;
    rv_trap_pkg::cause_t  irq_cause;
    logic                 irq_en;

    // Pins are sampled once, no synchroniser.
    always_ff @(posedge clk) begin
        irq_pending <= irq;
    end

    assign mie_hist_next = {mie_hist, mstatus_mie};

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= mie_hist_next[mie_delay-1:0];
        end
    end

    // MIE must be set now and at every recorded edge.
    assign irq_en     = mstatus_mie && (&mie_hist);
    assign irq_masked = irq_pending & mie[31:rv_trap_pkg::IRQ_BASE];

    // Scan downwards so the lowest line wins.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= rv_trap_pkg::IRQ_BASE; i--) begin
            if (irq_masked[i]) begin
                irq_cause = rv_trap_pkg::cause_t'(i);
            end
        end
    end

    // Interrupts take precedence over a retired trap.
    assign take_irq   = retire_valid && (|irq_masked) && irq_en;
    assign take_trap  = !take_irq && retire_trap;
    assign trap_cause = take_irq ? irq_cause : retire_cause;
    // Saved pc is word aligned.
    assign trap_epc   = {retire_pc[31:2], 1'b0};

    assign exception  = take_irq || take_trap;
    assign tvec       = mtvec;

endmodule

//--- hdl/trap_unit.sv
// Machine-mode trap unit top, joining the CSR file and the trap arbiter.
`timescale 1ns/10ps

module trap_unit #(
    // Value returned by mhartid.
    parameter rv_trap_pkg::xlen_t hartid = 32'h0000_0000,
    // Interrupt enable delay in clock edges.
    parameter int mie_delay = 2
) (
    input  logic                   clk,
    input  logic                   rst,

    // CSR access port.
    input  rv_trap_pkg::csr_addr_t csr_addr,
    input  logic                   csr_we,
    input  rv_trap_pkg::xlen_t     csr_wdata,
    output rv_trap_pkg::xlen_t     csr_rdata,
    output logic                   csr_exists,
    output logic                   csr_rdonly,

    // Retire port.
    input  logic                   retire_valid,
    input  logic                   retire_trap,
    input  rv_trap_pkg::cause_t    retire_cause,
    input  rv_trap_pkg::pc_t       retire_pc,
    input  logic                   mret,

    // External interrupts 16 to 31.
    input  rv_trap_pkg::irq_t      irq,

    // Redirect to the fetch stage.
    output logic                   exception,
    output rv_trap_pkg::tvec_t     tvec,
    output rv_trap_pkg::pc_t       ret_epc
);

    // CSR state towards the arbiter.
    logic                mstatus_mie;
    rv_trap_pkg::xlen_t  mie;
    rv_trap_pkg::tvec_t  mtvec;
    // Dispatch towards the CSR file.
    logic                take_irq;
    logic                take_trap;
    rv_trap_pkg::cause_t trap_cause;
    rv_trap_pkg::pc_t    trap_epc;
    rv_trap_pkg::irq_t   irq_pending;

    csr_file #(
        .hartid(hartid)
    ) u_csr_file (
        .clk         (clk),
        .rst         (rst),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .mret        (mret),
        .take_irq    (take_irq),
        .take_trap   (take_trap),
        .trap_cause  (trap_cause),
        .trap_epc    (trap_epc),
        .irq_pending (irq_pending),
        .mstatus_mie (mstatus_mie),
        .mie         (mie),
        .mtvec       (mtvec),
        // Return address straight from mepc.
        .mepc        (ret_epc)
    );

    trap_arbiter #(
        .mie_delay(mie_delay)
    ) u_trap_arbiter (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .retire_cause (retire_cause),
        .retire_pc    (retire_pc),
        .mstatus_mie  (mstatus_mie),
        .mie          (mie),
        .mtvec        (mtvec),
        .irq_pending  (irq_pending),
        .take_irq     (take_irq),
        .take_trap    (take_trap),
        .trap_cause   (trap_cause),
        .trap_epc     (trap_epc),
        .exception    (exception),
        .tvec         (tvec)
    );

endmodule

//--- test/trap_unit_properties.sv
// Trap unit assertions on exception gating and CSR permission flags.
`timescale 1ns/10ps

module trap_unit_properties (
    input logic clk,
    input logic rst,
    input logic exception,
    input logic retire_valid,
    input logic retire_trap,
    input logic csr_exists,
    input logic csr_rdonly
);

    // Number of failed assertions.
    int fail_count = 0;

    // Nothing dispatched right out of reset.
    reset_quiet: assert property (@(posedge clk) rst |=> !exception)
        else begin
            $error("exception high in the cycle after reset");
            fail_count++;
        end

    // A dispatch needs a retiring instruction or a trap.
    exception_source: assert property (@(posedge clk) disable iff (rst)
        exception |-> (retire_valid || retire_trap))
        else begin
            $error("exception without retire_valid or retire_trap");
            fail_count++;
        end

    // Read-only only for existing CSRs.
    rdonly_exists: assert property (@(posedge clk) csr_rdonly |-> csr_exists)
        else begin
            $error("csr_rdonly set for an absent CSR");
            fail_count++;
        end

endmodule

bind trap_unit trap_unit_properties u_properties (
    .clk          (clk),
    .rst          (rst),
    .exception    (exception),
    .retire_valid (retire_valid),
    .retire_trap  (retire_trap),
    .csr_exists   (csr_exists),
    .csr_rdonly   (csr_rdonly)
);

//--- test/trap_unit_tb.sv
// Trap unit testbench that runs a table of CSR, retire, interrupt and return steps.
`timescale 1ns/10ps

module trap_unit_tb;

    // Row operations.
    localparam int op_write  = 0;
    localparam int op_read   = 1;
    localparam int op_irq    = 2;
    localparam int op_retire = 3;
    localparam int op_trap   = 4;
    localparam int op_mret   = 5;
    localparam int op_idle   = 6;

    localparam rv_trap_pkg::xlen_t hart_value   = 32'h0000_0007;
    localparam rv_trap_pkg::xlen_t handler_base = 32'h0000_0400;

    logic                   clk;
    logic                   rst;
    rv_trap_pkg::csr_addr_t csr_addr;
    logic                   csr_we;
    rv_trap_pkg::xlen_t     csr_wdata;
    rv_trap_pkg::xlen_t     csr_rdata;
    logic                   csr_exists;
    logic                   csr_rdonly;
    logic                   retire_valid;
    logic                   retire_trap;
    rv_trap_pkg::cause_t    retire_cause;
    rv_trap_pkg::pc_t       retire_pc;
    logic                   mret;
    rv_trap_pkg::irq_t      irq;
    logic                   exception;
    rv_trap_pkg::tvec_t     tvec;
    rv_trap_pkg::pc_t       ret_epc;

    // Stimulus table.
    // Address column holds a CSR, a pc or an irq pattern.
    string              row_name[$];
    int                 row_op[$];
    rv_trap_pkg::xlen_t row_addr[$];
    rv_trap_pkg::xlen_t row_data[$];
    rv_trap_pkg::xlen_t row_exp[$];
    // Expected {exists, rdonly} on reads.
    logic [1:0]         row_flags[$];

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    trap_unit #(.hartid(hart_value), .mie_delay(2)) dut (.*);

    always #5 clk = ~clk;

    // Run limit.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: table not finished within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic csr_row(input string name, input int op, input rv_trap_pkg::csr_addr_t addr,
                           input rv_trap_pkg::xlen_t data, input rv_trap_pkg::xlen_t expv,
                           input logic [1:0] flags);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back({20'h0, addr});
        row_data.push_back(data);
        row_exp.push_back(expv);
        row_flags.push_back(flags);
    endtask

    task automatic event_row(input string name, input int op, input rv_trap_pkg::xlen_t where,
                             input rv_trap_pkg::xlen_t data, input rv_trap_pkg::xlen_t expv);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(where);
        row_data.push_back(data);
        row_exp.push_back(expv);
        row_flags.push_back(2'b00);
    endtask

    task automatic check_value(input string name, input rv_trap_pkg::xlen_t expv,
                               input rv_trap_pkg::xlen_t actual);
        checks++;
        if (actual !== expv) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expv, actual);
        end
    endtask

    initial begin
        rv_trap_pkg::xlen_t rnd [5];

        clk          = 1'b0;
        rst          = 1'b1;
        csr_addr     = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        retire_valid = 1'b0;
        retire_trap  = 1'b0;
        retire_cause = '0;
        retire_pc    = '0;
        mret         = 1'b0;
        irq          = '0;
        void'($urandom(32'h63c1f6e8));
        foreach (rnd[k]) rnd[k] = $urandom();

        // Reset values and identity.
        csr_row("rst_mstatus", op_read, rv_trap_pkg::CSR_MSTATUS, 0, 0, 2'b10);
        csr_row("rst_mie", op_read, rv_trap_pkg::CSR_MIE, 0, 0, 2'b10);
        csr_row("rst_mtvec", op_read, rv_trap_pkg::CSR_MTVEC, 0, 0, 2'b10);
        csr_row("rst_mscratch", op_read, rv_trap_pkg::CSR_MSCRATCH, 0, 0, 2'b10);
        csr_row("rst_mepc", op_read, rv_trap_pkg::CSR_MEPC, 0, 0, 2'b10);
        csr_row("rst_mcause", op_read, rv_trap_pkg::CSR_MCAUSE, 0, 0, 2'b10);
        csr_row("rst_misa", op_read, rv_trap_pkg::CSR_MISA, 0, rv_trap_pkg::MISA_VALUE, 2'b10);
        csr_row("rst_mhartid", op_read, rv_trap_pkg::CSR_MHARTID, 0, hart_value, 2'b11);
        csr_row("rst_mvendorid", op_read, rv_trap_pkg::CSR_MVENDORID, 0, 0, 2'b11);
        csr_row("rst_unlisted", op_read, 12'h7c0, 0, 0, 2'b00);
        // Write masking with random words.
        csr_row("mscratch_wr", op_write, rv_trap_pkg::CSR_MSCRATCH, rnd[0], 0, 2'b00);
        csr_row("mscratch_rd", op_read, rv_trap_pkg::CSR_MSCRATCH, 0, rnd[0], 2'b10);
        csr_row("mie_wr", op_write, rv_trap_pkg::CSR_MIE, rnd[1], 0, 2'b00);
        csr_row("mie_rd", op_read, rv_trap_pkg::CSR_MIE, 0, rnd[1], 2'b10);
        csr_row("mtvec_wr", op_write, rv_trap_pkg::CSR_MTVEC, rnd[2], 0, 2'b00);
        csr_row("mtvec_rd", op_read, rv_trap_pkg::CSR_MTVEC, 0, rnd[2] & 32'hffff_fffc, 2'b10);
        csr_row("mepc_wr", op_write, rv_trap_pkg::CSR_MEPC, rnd[3], 0, 2'b00);
        csr_row("mepc_rd", op_read, rv_trap_pkg::CSR_MEPC, 0, rnd[3] & 32'hffff_fffe, 2'b10);
        csr_row("mcause_wr", op_write, rv_trap_pkg::CSR_MCAUSE, rnd[4], 0, 2'b00);
        csr_row("mcause_rd", op_read, rv_trap_pkg::CSR_MCAUSE, 0, rnd[4] & 32'h8000_001f, 2'b10);
        // Synchronous trap with MIE set and no interrupt enabled.
        csr_row("trap_mtvec", op_write, rv_trap_pkg::CSR_MTVEC, handler_base, 0, 2'b00);
        csr_row("trap_mie", op_write, rv_trap_pkg::CSR_MIE, 0, 0, 2'b00);
        csr_row("trap_mstatus", op_write, rv_trap_pkg::CSR_MSTATUS, 32'h8, 0, 2'b00);
        event_row("trap_take", op_trap, 32'h0000_1236, 2, 1);
        csr_row("trap_mepc", op_read, rv_trap_pkg::CSR_MEPC, 0, 32'h0000_1234, 2'b10);
        csr_row("trap_mcause", op_read, rv_trap_pkg::CSR_MCAUSE, 0, 32'h2, 2'b10);
        csr_row("trap_status", op_read, rv_trap_pkg::CSR_MSTATUS, 0, 32'h80, 2'b10);
        // Return restores MIE, MPIE stays set.
        event_row("ret_epc", op_mret, 0, 0, 32'h0000_1234);
        csr_row("ret_status", op_read, rv_trap_pkg::CSR_MSTATUS, 0, 32'h88, 2'b10);
        // Lines 17, 21, 23, 30 raised, lines 18, 21, 23 enabled.
        csr_row("irq_mie_off", op_write, rv_trap_pkg::CSR_MSTATUS, 0, 0, 2'b00);
        csr_row("irq_enable", op_write, rv_trap_pkg::CSR_MIE, 32'h00a4_0000, 0, 2'b00);
        event_row("irq_raise", op_irq, 32'h40a2_0000, 0, 0);
        csr_row("irq_mip", op_read, rv_trap_pkg::CSR_MIP, 0, 32'h00a0_0000, 2'b10);
        event_row("irq_gated_off", op_retire, 32'h0000_3000, 0, 0);
        csr_row("irq_mie_on", op_write, rv_trap_pkg::CSR_MSTATUS, 32'h8, 0, 2'b00);
        // Enable history not yet full.
        event_row("irq_delay", op_retire, 32'h0000_3004, 0, 0);
        event_row("irq_delay_b", op_retire, 32'h0000_3008, 0, 0);
        event_row("irq_no_retire", op_idle, 0, 0, 0);
        // Interrupt wins over the retired trap.
        event_row("irq_take", op_trap, 32'h0000_200a, 7, 1);
        csr_row("irq_mcause", op_read, rv_trap_pkg::CSR_MCAUSE, 0, 32'h8000_0015, 2'b10);
        csr_row("irq_mepc", op_read, rv_trap_pkg::CSR_MEPC, 0, 32'h0000_2008, 2'b10);
        csr_row("irq_status", op_read, rv_trap_pkg::CSR_MSTATUS, 0, 32'h80, 2'b10);
        event_row("irq_ret", op_mret, 0, 0, 32'h0000_2008);
        csr_row("irq_ret_status", op_read, rv_trap_pkg::CSR_MSTATUS, 0, 32'h88, 2'b10);
        csr_row("irq_ret_mip", op_read, rv_trap_pkg::CSR_MIP, 0, 32'h00a0_0000, 2'b10);
        event_row("irq_drop", op_irq, 0, 0, 0);
        cycle_limit = row_name.size() * 24 + 16 + 200;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < row_name.size(); i++) begin
            // Strobes last one cycle.
            @(negedge clk);
            csr_we       = 1'b0;
            retire_valid = 1'b0;
            retire_trap  = 1'b0;
            mret         = 1'b0;
            case (row_op[i])
                op_write: begin
                    csr_addr  = row_addr[i][11:0];
                    csr_wdata = row_data[i];
                    csr_we    = 1'b1;
                end
                op_read: begin
                    csr_addr = row_addr[i][11:0];
                    #2;
                    check_value(row_name[i], row_exp[i], csr_rdata);
                    check_value({row_name[i], "_flags"}, rv_trap_pkg::xlen_t'(row_flags[i]),
                                rv_trap_pkg::xlen_t'({csr_exists, csr_rdonly}));
                end
                op_irq: irq = row_addr[i][31:16];
                op_retire, op_trap: begin
                    retire_valid = 1'b1;
                    retire_trap  = (row_op[i] == op_trap);
                    retire_cause = row_data[i][4:0];
                    retire_pc    = row_addr[i][31:1];
                    #2;
                    check_value(row_name[i], row_exp[i], rv_trap_pkg::xlen_t'(exception));
                    if (row_exp[i][0]) begin
                        check_value({row_name[i], "_tvec"}, handler_base, {tvec, 2'b00});
                    end
                end
                op_mret: begin
                    mret = 1'b1;
                    #2;
                    check_value(row_name[i], row_exp[i], {ret_epc, 1'b0});
                end
                default: begin
                    #2;
                    check_value(row_name[i], 0, rv_trap_pkg::xlen_t'(exception));
                end
            endcase
            @(posedge clk);
        end

        @(negedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut.u_properties.fail_count);
        if (errors == 0 && dut.u_properties.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/rv_trap_pkg.sv
hdl/csr_file.sv
hdl/trap_arbiter.sv
hdl/trap_unit.sv
test/trap_unit_properties.sv
test/trap_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := trap_unit_tb
FILELIST   := list.f
FLAGS      := --timing --assert --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+100
FAIL_MSG   := TEST FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
